// File: project.f
+incdir+source
source/csr_pkg.sv
source/csr_access.sv
source/csr_trap_regs.sv
source/csr_counters.sv
source/csr_file.sv
testbench/csr_file_tb.sv

// File: run.sh
#!/bin/sh
# build and run the csr file testbench with verilator, fail on the fail message in the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --assert -f project.f --top-module csr_file_tb -o csr_file_sim \
  && ./obj_dir/csr_file_sim > sim.log 2>&1 \
  || echo "TESTBENCH FAILED: build or simulation error" >> sim.log
cat sim.log
if grep -q "TESTBENCH FAILED" sim.log; then
  exit 1
fi
exit 0

// File: source/csr_access.sv
/* csr access unit: read mux by address and read-modify-write
   data for write, set and clear, purely combinational */

`include "csr_defines.svh"

module csr_access (
  input  csr_pkg::csr_req_t    req_i,
  input  logic [`CSR_XLEN-1:0] hart_id_i,
  input  csr_pkg::trap_view_t  trap_view_i,
  input  csr_pkg::cnt_view_t   cnt_view_i,
  output logic [`CSR_XLEN-1:0] rdata_o,
  output csr_pkg::csr_wr_t     wr_o
);

  import csr_pkg::*;

  logic [`CSR_XLEN-1:0] rdata;  // old value of the addressed csr
  logic [`CSR_XLEN-1:0] wdata;  // merged write data

  ////////////////////////////////////////////////////////////
  // read mux
  ////////////////////////////////////////////////////////////

  always_comb begin
    case (req_i.addr)
      // trap registers
      CSR_MSTATUS:       rdata = trap_view_i.mstatus;
      CSR_MIE:           rdata = trap_view_i.mie;
      CSR_MTVEC:         rdata = trap_view_i.mtvec;
      CSR_MSCRATCH:      rdata = trap_view_i.mscratch;
      CSR_MEPC:          rdata = trap_view_i.mepc;
      CSR_MCAUSE:        rdata = trap_view_i.mcause;
      // counters, split in halves
      CSR_MCOUNTINHIBIT: rdata = cnt_view_i.mcountinhibit;
      CSR_MCYCLE:        rdata = cnt_view_i.mcycle[31:0];
      CSR_MCYCLEH:       rdata = cnt_view_i.mcycle[63:32];
      CSR_MINSTRET:      rdata = cnt_view_i.minstret[31:0];
      CSR_MINSTRETH:     rdata = cnt_view_i.minstret[63:32];
      // identity, read only
      CSR_MISA:          rdata = `CSR_MISA_VALUE;
      CSR_MVENDORID:     rdata = `CSR_MVENDORID_VALUE;
      CSR_MARCHID:       rdata = `CSR_MARCHID_VALUE;
      CSR_MHARTID:       rdata = hart_id_i;
      // not implemented, tied off
      CSR_MIMPID,
      CSR_MTVAL:         rdata = '0;
      default:           rdata = '0;  // unknown address
    endcase
  end

  assign rdata_o = rdata;  // value before the access

  ////////////////////////////////////////////////////////////
  // write data
  ////////////////////////////////////////////////////////////

  always_comb begin
    case (req_i.op)
      CSR_OP_SET:   wdata = rdata | req_i.wdata;
      CSR_OP_CLEAR: wdata = rdata & ~req_i.wdata;
      default:      wdata = req_i.wdata;  // write, and don't care for read
    endcase
  end

  // register blocks decode the address themselves
  assign wr_o.we   = req_i.valid && (req_i.op != CSR_OP_READ);
  assign wr_o.addr = req_i.addr;
  assign wr_o.data = wdata;

endmodule

// File: source/csr_counters.sv
/* mcycle and minstret 64-bit counters with mcountinhibit,
   half-word csr writes take priority over counting */

`include "csr_defines.svh"

module csr_counters (
  input  logic                clk,
  input  logic                rst_n,
  input  csr_pkg::csr_wr_t    wr_i,
  input  logic                retire_i,
  output csr_pkg::cnt_view_t  view_o
);

  import csr_pkg::*;

  localparam logic [`CSR_XLEN-1:0] INH_RESET = `CSR_MCNTINH_RESET;

  logic [63:0] mcycle_q, minstret_q;
  logic        inh_cy_q, inh_ir_q;  // mcountinhibit bits 0 and 2
  logic        wr_cy_lo, wr_cy_hi;
  logic        wr_ir_lo, wr_ir_hi;
  logic        wr_inh;

  // one counter step: lower half, upper half, then increment
  function automatic logic [63:0] cnt_next(
    input logic [63:0]          cur,
    input logic                 wr_lo,
    input logic                 wr_hi,
    input logic                 inc,
    input logic [`CSR_XLEN-1:0] data
  );
    logic [63:0] nxt;
    nxt = cur;
    if (wr_lo) begin
      nxt[31:0] = data;
    end else if (wr_hi) begin
      nxt[63:32] = data;
    end else if (inc) begin
      nxt = cur + 64'd1;  // carries into the upper word
    end
    return nxt;
  endfunction

  // address decode
  assign wr_cy_lo = wr_i.we && (wr_i.addr == CSR_MCYCLE);
  assign wr_cy_hi = wr_i.we && (wr_i.addr == CSR_MCYCLEH);
  assign wr_ir_lo = wr_i.we && (wr_i.addr == CSR_MINSTRET);
  assign wr_ir_hi = wr_i.we && (wr_i.addr == CSR_MINSTRETH);
  assign wr_inh   = wr_i.we && (wr_i.addr == CSR_MCOUNTINHIBIT);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      mcycle_q   <= '0;
      minstret_q <= '0;
      inh_cy_q   <= INH_RESET[0];
      inh_ir_q   <= INH_RESET[2];
    end else begin
      mcycle_q   <= cnt_next(mcycle_q, wr_cy_lo, wr_cy_hi, !inh_cy_q, wr_i.data);
      minstret_q <= cnt_next(minstret_q, wr_ir_lo, wr_ir_hi, !inh_ir_q && retire_i,
                             wr_i.data);
      if (wr_inh) begin
        inh_cy_q <= wr_i.data[0];
        inh_ir_q <= wr_i.data[2];
      end
    end
  end

  assign view_o.mcycle        = mcycle_q;
  assign view_o.minstret      = minstret_q;
  assign view_o.mcountinhibit = {29'd0, inh_ir_q, 1'b0, inh_cy_q};  // unused bits read 0

  // stopped mcycle only moves on a csr write
  a_mcycle_frozen : assert property (
    @(posedge clk) disable iff (!rst_n)
    (view_o.mcountinhibit[0] && !wr_cy_lo && !wr_cy_hi) |=> $stable(mcycle_q)
  ) else $error("mcycle moved while inhibited");

endmodule

// File: source/csr_defines.svh
/* data width, reset values, write masks and id constants
   for the machine-mode csr file */

`ifndef CSR_DEFINES_SVH
`define CSR_DEFINES_SVH

// register width
`define CSR_XLEN            32

// reset values
`define CSR_MTVEC_RESET     32'h0000_0100  // base 0x100, direct mode
`define CSR_MSTATUS_RESET   32'h0000_1800  // mpp = 3, mie = mpie = 0
`define CSR_MCNTINH_RESET   32'h0000_0005  // both counters stopped out of reset

// write masks
`define CSR_IRQ_MASK        32'h0000_0888  // msie, mtie, meie
`define CSR_MEPC_MASK       32'hFFFF_FFFE  // halfword aligned
`define CSR_MCAUSE_MASK     32'h8000_001F  // interrupt flag + 5-bit code

// identity
`define CSR_MISA_VALUE      32'h4000_1104  // mxl = 1, i, m, c
`define CSR_MVENDORID_VALUE 32'h0000_0000  // non-commercial
`define CSR_MARCHID_VALUE   32'h0000_0021

`endif

// File: source/csr_file.sv
/* machine-mode csr file top: access unit, trap registers, counters */

`include "csr_defines.svh"

module csr_file (
  input  logic                  clk,
  input  logic                  rst_n,
  input  csr_pkg::csr_req_t     req_i,
  input  csr_pkg::trap_t        trap_i,
  input  logic                  mret_i,
  input  logic                  retire_i,
  input  logic [`CSR_XLEN-1:0]  hart_id_i,
  output logic [`CSR_XLEN-1:0]  rdata_o,
  output logic [`CSR_XLEN-1:0]  mepc_o,
  output logic [23:0]           mtvec_base_o,
  output logic [1:0]            mtvec_mode_o,
  output logic [`CSR_XLEN-1:0]  mie_o,
  output logic                  m_irq_enable_o
);

  import csr_pkg::*;

  csr_wr_t    csr_wr;     // resolved write to both register blocks
  trap_view_t trap_view;
  cnt_view_t  cnt_view;

  csr_access u_access (
    .req_i       (req_i),
    .hart_id_i   (hart_id_i),
    .trap_view_i (trap_view),
    .cnt_view_i  (cnt_view),
    .rdata_o     (rdata_o),
    .wr_o        (csr_wr)
  );

  csr_trap_regs u_trap (
    .clk            (clk),
    .rst_n          (rst_n),
    .wr_i           (csr_wr),
    .trap_i         (trap_i),
    .mret_i         (mret_i),
    .view_o         (trap_view),
    .mepc_o         (mepc_o),
    .mtvec_base_o   (mtvec_base_o),
    .mtvec_mode_o   (mtvec_mode_o),
    .mie_o          (mie_o),
    .m_irq_enable_o (m_irq_enable_o)
  );

  csr_counters u_cnt (
    .clk      (clk),
    .rst_n    (rst_n),
    .wr_i     (csr_wr),
    .retire_i (retire_i),
    .view_o   (cnt_view)
  );

endmodule

// File: source/csr_pkg.sv
/* csr opcode and address enums, access, write and trap structs,
   register layouts and the read views of the register blocks */

`include "csr_defines.svh"

package csr_pkg;

  // csr instruction flavours
  typedef enum logic [1:0] {
    CSR_OP_READ  = 2'b00,
    CSR_OP_WRITE = 2'b01,
    CSR_OP_SET   = 2'b10,
    CSR_OP_CLEAR = 2'b11
  } csr_op_e;

  // implemented csr addresses
  typedef enum logic [11:0] {
    CSR_MSTATUS       = 12'h300,
    CSR_MISA          = 12'h301,
    CSR_MIE           = 12'h304,
    CSR_MTVEC         = 12'h305,
    CSR_MCOUNTINHIBIT = 12'h320,
    CSR_MSCRATCH      = 12'h340,
    CSR_MEPC          = 12'h341,
    CSR_MCAUSE        = 12'h342,
    CSR_MTVAL         = 12'h343,
    CSR_MCYCLE        = 12'hB00,
    CSR_MINSTRET      = 12'hB02,
    CSR_MCYCLEH       = 12'hB80,
    CSR_MINSTRETH     = 12'hB82,
    CSR_MVENDORID     = 12'hF11,
    CSR_MARCHID       = 12'hF12,
    CSR_MIMPID        = 12'hF13,
    CSR_MHARTID       = 12'hF14
  } csr_num_e;

  typedef struct packed {
    logic                 valid;
    csr_op_e              op;
    csr_num_e             addr;
    logic [`CSR_XLEN-1:0] wdata;
  } csr_req_t;

  // resolved write, data already merged for set/clear
  typedef struct packed {
    logic                 we;
    csr_num_e             addr;
    logic [`CSR_XLEN-1:0] data;
  } csr_wr_t;

  typedef struct packed {
    logic                 take;  // one-cycle pulse
    logic                 irq;
    logic [4:0]           code;
    logic [`CSR_XLEN-1:0] pc;
  } trap_t;

  typedef struct packed {
    logic [18:0] zero3;
    logic [1:0]  mpp;    // [12:11]
    logic [2:0]  zero2;
    logic        mpie;   // [7]
    logic [2:0]  zero1;
    logic        mie;    // [3]
    logic [2:0]  zero0;
  } mstatus_t;

  typedef struct packed {
    logic [23:0] base;
    logic [5:0]  zero;
    logic [1:0]  mode;
  } mtvec_t;

  typedef struct packed {
    mstatus_t             mstatus;
    logic [`CSR_XLEN-1:0] mie;
    mtvec_t               mtvec;
    logic [`CSR_XLEN-1:0] mscratch;
    logic [`CSR_XLEN-1:0] mepc;
    logic [`CSR_XLEN-1:0] mcause;
  } trap_view_t;

  typedef struct packed {
    logic [63:0]          mcycle;
    logic [63:0]          minstret;
    logic [`CSR_XLEN-1:0] mcountinhibit;
  } cnt_view_t;

endpackage

// File: source/csr_trap_regs.sv
/* machine trap registers: mstatus, mie, mtvec, mscratch, mepc, mcause
   with masked csr writes, trap entry and mret update */

`include "csr_defines.svh"

module csr_trap_regs (
  input  logic                  clk,
  input  logic                  rst_n,
  input  csr_pkg::csr_wr_t      wr_i,
  input  csr_pkg::trap_t        trap_i,
  input  logic                  mret_i,
  output csr_pkg::trap_view_t   view_o,
  output logic [`CSR_XLEN-1:0]  mepc_o,
  output logic [23:0]           mtvec_base_o,
  output logic [1:0]            mtvec_mode_o,
  output logic [`CSR_XLEN-1:0]  mie_o,
  output logic                  m_irq_enable_o
);

  import csr_pkg::*;

  mstatus_t             mstatus_q, mstatus_n;
  mtvec_t               mtvec_q, mtvec_n;
  logic [`CSR_XLEN-1:0] mie_q, mie_n;
  logic [`CSR_XLEN-1:0] mscratch_q, mscratch_n;
  logic [`CSR_XLEN-1:0] mepc_q, mepc_n;
  logic [`CSR_XLEN-1:0] mcause_q, mcause_n;

  ////////////////////////////////////////////////////////////
  // next state
  ////////////////////////////////////////////////////////////

  always_comb begin
    mstatus_n  = mstatus_q;
    mtvec_n    = mtvec_q;
    mie_n      = mie_q;
    mscratch_n = mscratch_q;
    mepc_n     = mepc_q;
    mcause_n   = mcause_q;

    // csr writes, masked per register
    if (wr_i.we) begin
      case (wr_i.addr)
        CSR_MSTATUS: begin
          mstatus_n.mie  = wr_i.data[3];
          mstatus_n.mpie = wr_i.data[7];  // mpp stays at machine
        end
        CSR_MIE:      mie_n = wr_i.data & `CSR_IRQ_MASK;
        CSR_MTVEC: begin
          mtvec_n.base = wr_i.data[31:8];
          mtvec_n.mode = {1'b0, wr_i.data[0]};  // direct or vectored
        end
        CSR_MSCRATCH: mscratch_n = wr_i.data;
        CSR_MEPC:     mepc_n = wr_i.data & `CSR_MEPC_MASK;
        CSR_MCAUSE:   mcause_n = wr_i.data & `CSR_MCAUSE_MASK;
        default: ;  // not ours
      endcase
    end

    // trap and mret override a csr write in the same cycle
    if (trap_i.take) begin
      mstatus_n.mpie = mstatus_q.mie;  // stash enable
      mstatus_n.mie  = 1'b0;           // handler runs with irqs off
      mepc_n         = trap_i.pc & `CSR_MEPC_MASK;
      mcause_n       = {trap_i.irq, 26'd0, trap_i.code};
    end else if (mret_i) begin
      mstatus_n.mie  = mstatus_q.mpie;
      mstatus_n.mpie = 1'b1;
    end
  end

  ////////////////////////////////////////////////////////////
  // registers
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      mstatus_q  <= `CSR_MSTATUS_RESET;
      mtvec_q    <= `CSR_MTVEC_RESET;
      mie_q      <= '0;  // all irqs masked
      mscratch_q <= '0;
      mepc_q     <= '0;
      mcause_q   <= '0;
    end else begin
      mstatus_q  <= mstatus_n;
      mtvec_q    <= mtvec_n;
      mie_q      <= mie_n;
      mscratch_q <= mscratch_n;
      mepc_q     <= mepc_n;
      mcause_q   <= mcause_n;
    end
  end

  // read view for the access unit
  assign view_o.mstatus  = mstatus_q;
  assign view_o.mie      = mie_q;
  assign view_o.mtvec    = mtvec_q;
  assign view_o.mscratch = mscratch_q;
  assign view_o.mepc     = mepc_q;
  assign view_o.mcause   = mcause_q;

  // core side
  assign mepc_o         = mepc_q;
  assign mtvec_base_o   = mtvec_q.base;
  assign mtvec_mode_o   = mtvec_q.mode;
  assign mie_o          = mie_q;
  assign m_irq_enable_o = mstatus_q.mie;

  // controller never enters and leaves a trap in one cycle
  a_trap_mret_excl : assert property (
    @(posedge clk) disable iff (!rst_n) !(trap_i.take && mret_i)
  ) else $error("trap entry and mret in the same cycle");

endmodule

// File: testbench/csr_file_tb.sv
/* csr file testbench: clock, reset, directed and random csr accesses,
   a reference model of every register and the checking assertions */

`include "csr_defines.svh"

module csr_file_tb;

  import csr_pkg::*;

  localparam csr_num_e RW_CSR [5] = '{CSR_MSTATUS, CSR_MIE, CSR_MTVEC, CSR_MEPC, CSR_MCAUSE};

  logic                 clk;
  logic                 rst_n;
  csr_req_t             req;
  trap_t                trap;
  logic                 mret;
  logic                 retire;
  logic [`CSR_XLEN-1:0] hart_id;
  logic [`CSR_XLEN-1:0] rdata, mepc, mie;
  logic [23:0]          mtvec_base;
  logic [1:0]           mtvec_mode;
  logic                 irq_en;

  // reference model state
  logic [31:0] md_mstatus, md_mie, md_mtvec, md_mscratch, md_mepc, md_mcause, md_inh;
  logic [63:0] md_mcycle, md_minstret;
  logic [31:0] exp_rdata;  // model value of the addressed csr

  integer seed, err_cnt, err_mark, test_cnt, fail_cnt;
  logic   timeout_hit;

  csr_file i_dut (
    .clk            (clk),
    .rst_n          (rst_n),
    .req_i          (req),
    .trap_i         (trap),
    .mret_i         (mret),
    .retire_i       (retire),
    .hart_id_i      (hart_id),
    .rdata_o        (rdata),
    .mepc_o         (mepc),
    .mtvec_base_o   (mtvec_base),
    .mtvec_mode_o   (mtvec_mode),
    .mie_o          (mie),
    .m_irq_enable_o (irq_en)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  ////////////////////////////////////////////////////////////
  // reference model
  ////////////////////////////////////////////////////////////

  always_comb begin
    case (req.addr)
      CSR_MSTATUS:       exp_rdata = md_mstatus;
      CSR_MIE:           exp_rdata = md_mie;
      CSR_MTVEC:         exp_rdata = md_mtvec;
      CSR_MSCRATCH:      exp_rdata = md_mscratch;
      CSR_MEPC:          exp_rdata = md_mepc;
      CSR_MCAUSE:        exp_rdata = md_mcause;
      CSR_MCOUNTINHIBIT: exp_rdata = md_inh;
      CSR_MCYCLE:        exp_rdata = md_mcycle[31:0];
      CSR_MCYCLEH:       exp_rdata = md_mcycle[63:32];
      CSR_MINSTRET:      exp_rdata = md_minstret[31:0];
      CSR_MINSTRETH:     exp_rdata = md_minstret[63:32];
      CSR_MISA:          exp_rdata = `CSR_MISA_VALUE;
      CSR_MVENDORID:     exp_rdata = `CSR_MVENDORID_VALUE;
      CSR_MARCHID:       exp_rdata = `CSR_MARCHID_VALUE;
      CSR_MHARTID:       exp_rdata = hart_id;
      default:           exp_rdata = '0;  // mimpid, mtval, unknown
    endcase
  end

  always @(posedge clk or negedge rst_n) begin : ref_model
    logic [31:0] nv;
    logic [63:0] cy, ir;
    if (!rst_n) begin
      md_mstatus  <= `CSR_MSTATUS_RESET;
      md_mtvec    <= `CSR_MTVEC_RESET;
      md_inh      <= `CSR_MCNTINH_RESET;
      md_mie      <= '0;
      md_mscratch <= '0;
      md_mepc     <= '0;
      md_mcause   <= '0;
      md_mcycle   <= '0;
      md_minstret <= '0;
    end else begin
      case (req.op)
        CSR_OP_WRITE: nv = req.wdata;
        CSR_OP_SET:   nv = exp_rdata | req.wdata;
        CSR_OP_CLEAR: nv = exp_rdata & ~req.wdata;
        default:      nv = exp_rdata;
      endcase
      cy = md_mcycle + {63'd0, !md_inh[0]};
      ir = md_minstret + {63'd0, !md_inh[2] && retire};
      if (req.valid && req.op != CSR_OP_READ) begin
        case (req.addr)
          CSR_MSTATUS:       md_mstatus <= `CSR_MSTATUS_RESET | {24'd0, nv[7], 3'd0, nv[3], 3'd0};
          CSR_MIE:           md_mie <= nv & `CSR_IRQ_MASK;
          CSR_MTVEC:         md_mtvec <= {nv[31:8], 7'd0, nv[0]};
          CSR_MSCRATCH:      md_mscratch <= nv;
          CSR_MEPC:          md_mepc <= {nv[31:1], 1'b0};
          CSR_MCAUSE:        md_mcause <= {nv[31], 26'd0, nv[4:0]};
          CSR_MCOUNTINHIBIT: md_inh <= {29'd0, nv[2], 1'b0, nv[0]};
          CSR_MCYCLE:        cy = {md_mcycle[63:32], nv};  // write beats count
          CSR_MCYCLEH:       cy = {nv, md_mcycle[31:0]};
          CSR_MINSTRET:      ir = {md_minstret[63:32], nv};
          CSR_MINSTRETH:     ir = {nv, md_minstret[31:0]};
          default: ;
        endcase
      end
      md_mcycle   <= cy;
      md_minstret <= ir;
      // later assignments win over the csr write
      if (trap.take) begin
        md_mepc    <= {trap.pc[31:1], 1'b0};
        md_mcause  <= {trap.irq, 26'd0, trap.code};
        md_mstatus <= `CSR_MSTATUS_RESET | {24'd0, md_mstatus[3], 7'd0};  // mpie = mie
      end else if (mret) begin
        md_mstatus <= `CSR_MSTATUS_RESET | {24'd0, 1'b1, 3'd0, md_mstatus[7], 3'd0};
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // checks
  ////////////////////////////////////////////////////////////

  a_rdata : assert property (@(posedge clk) disable iff (!rst_n)
    req.valid |-> (rdata == exp_rdata))
  else begin
    err_cnt = err_cnt + 1;
    $display("mismatch at %0t: csr %h read %h, expected %h", $time,
             $sampled(req.addr), $sampled(rdata), $sampled(exp_rdata));
  end

  a_core_out : assert property (@(posedge clk) disable iff (!rst_n)
    mepc == md_mepc && mie == md_mie && mtvec_base == md_mtvec[31:8]
    && mtvec_mode == md_mtvec[1:0] && irq_en == md_mstatus[3])
  else begin
    err_cnt = err_cnt + 1;
    $display("mismatch at %0t: core outputs mepc %h mie %h irq_en %b, expected %h %h %b",
             $time, $sampled(mepc), $sampled(mie), $sampled(irq_en),
             $sampled(md_mepc), $sampled(md_mie), $sampled(md_mstatus[3]));
  end

  ////////////////////////////////////////////////////////////
  // stimulus helpers
  ////////////////////////////////////////////////////////////

  function automatic csr_req_t make_req(input csr_op_e op, input csr_num_e a,
                                        input logic [31:0] d);
    return '{valid: 1'b1, op: op, addr: a, wdata: d};
  endfunction

  // one cycle of inputs, every input set each time
  task automatic drive(input csr_req_t r, input trap_t t, input logic m, input logic ret);
    @(posedge clk);
    req    <= r;
    trap   <= t;
    mret   <= m;
    retire <= ret;
  endtask

  task automatic access(input csr_op_e op, input csr_num_e a, input logic [31:0] d);
    drive(make_req(op, a, d), '0, 1'b0, 1'b0);
  endtask

  task automatic idle(input integer n);
    repeat (n) drive('0, '0, 1'b0, 1'b0);
  endtask

  task automatic end_test(input string name);
    idle(2);  // let the last checks fire
    $display("test %-9s %0d errors", name, err_cnt - err_mark);
    test_cnt = test_cnt + 1;
    if (err_cnt != err_mark) fail_cnt = fail_cnt + 1;
    err_mark = err_cnt;
  endtask

  ////////////////////////////////////////////////////////////
  // test sequence
  ////////////////////////////////////////////////////////////

  initial begin
    logic [31:0] rnd, hi;
    integer      n;
    logic        carried;
    seed = 9;
    err_cnt = 0;
    err_mark = 0;
    test_cnt = 0;
    fail_cnt = 0;
    timeout_hit = 1'b0;
    rst_n = 1'b0;
    req = '0;
    trap = '0;
    mret = 1'b0;
    retire = 1'b0;
    hart_id = $random(seed);
    repeat (4) @(posedge clk);
    rst_n <= 1'b1;

    // reset values, mcycle inhibited
    access(CSR_OP_READ, CSR_MSTATUS, '0);
    access(CSR_OP_READ, CSR_MTVEC, '0);
    access(CSR_OP_READ, CSR_MCOUNTINHIBIT, '0);
    repeat (4) access(CSR_OP_READ, CSR_MCYCLE, '0);
    end_test("reset");

    // random opcodes on mscratch, each followed by a read
    repeat (40) begin
      rnd = $random(seed);
      access(csr_op_e'(rnd[1:0]), CSR_MSCRATCH, $random(seed));
      access(CSR_OP_READ, CSR_MSCRATCH, '0);
    end
    end_test("opcodes");

    // field masks, constants, read-only and unknown addresses
    repeat (6) begin
      for (int i = 0; i < 5; i++) begin
        access(CSR_OP_WRITE, RW_CSR[i], $random(seed));
        access(CSR_OP_READ, RW_CSR[i], '0);
      end
    end
    access(CSR_OP_READ, CSR_MISA, '0);
    access(CSR_OP_READ, CSR_MVENDORID, '0);
    access(CSR_OP_READ, CSR_MARCHID, '0);
    hart_id <= $random(seed);  // new id under a pending read
    access(CSR_OP_READ, CSR_MHARTID, '0);
    access(CSR_OP_WRITE, CSR_MISA, $random(seed));
    access(CSR_OP_SET, CSR_MHARTID, $random(seed));
    access(CSR_OP_WRITE, csr_num_e'(12'h7C0), $random(seed));
    access(CSR_OP_READ, CSR_MISA, '0);
    access(CSR_OP_READ, CSR_MHARTID, '0);
    access(CSR_OP_READ, csr_num_e'(12'h7C0), '0);
    access(CSR_OP_READ, CSR_MIMPID, '0);
    access(CSR_OP_READ, CSR_MTVAL, '0);
    access(CSR_OP_READ, CSR_MSCRATCH, '0);
    end_test("masks");

    // trap entry, mret, trap against a same-cycle mepc write
    access(CSR_OP_SET, CSR_MSTATUS, 32'h8);
    rnd = $random(seed);
    drive('0, '{take: 1'b1, irq: rnd[31], code: rnd[4:0], pc: {rnd[30:0], 1'b0}}, 1'b0, 1'b0);
    access(CSR_OP_READ, CSR_MEPC, '0);
    access(CSR_OP_READ, CSR_MCAUSE, '0);
    access(CSR_OP_READ, CSR_MSTATUS, '0);
    drive('0, '0, 1'b1, 1'b0);  // mret
    access(CSR_OP_READ, CSR_MSTATUS, '0);
    rnd = $random(seed);
    drive(make_req(CSR_OP_WRITE, CSR_MEPC, $random(seed)),
          '{take: 1'b1, irq: rnd[0], code: rnd[5:1], pc: {rnd[31:1], 1'b0}}, 1'b0, 1'b0);
    access(CSR_OP_READ, CSR_MEPC, '0);
    end_test("trap");

    // counters: free running, retire count, carry, freeze
    access(CSR_OP_WRITE, CSR_MCOUNTINHIBIT, '0);
    access(CSR_OP_READ, CSR_MCYCLE, '0);
    rnd = $random(seed);
    idle(3 + rnd[3:0]);
    access(CSR_OP_READ, CSR_MCYCLE, '0);
    repeat (20) begin
      rnd = $random(seed);
      drive('0, '0, 1'b0, rnd[0]);
    end
    access(CSR_OP_READ, CSR_MINSTRET, '0);
    access(CSR_OP_READ, CSR_MINSTRETH, '0);
    hi = $random(seed);
    access(CSR_OP_WRITE, CSR_MCYCLEH, hi);
    access(CSR_OP_WRITE, CSR_MCYCLE, 32'hFFFF_FFF0);
    n = 0;
    carried = 1'b0;
    while (!carried && n < 64) begin  // poll mcycleh until the carry lands
      access(CSR_OP_READ, CSR_MCYCLEH, '0);
      @(negedge clk);
      carried = (rdata == hi + 32'd1);
      n = n + 1;
    end
    if (!carried) begin
      timeout_hit = 1'b1;
      err_cnt = err_cnt + 1;
      $display("timeout: mcycle low word never carried into mcycleh");
    end else begin
      access(CSR_OP_WRITE, CSR_MCOUNTINHIBIT, 32'h5);
      access(CSR_OP_READ, CSR_MCYCLE, '0);
      repeat (6) drive('0, '0, 1'b0, 1'b1);  // retire pulses, ignored now
      access(CSR_OP_READ, CSR_MCYCLE, '0);
      access(CSR_OP_READ, CSR_MINSTRET, '0);
    end
    end_test("counters");

    $display("tests %0d, failed %0d, errors %0d", test_cnt, fail_cnt, err_cnt);
    if (err_cnt == 0 && !timeout_hit) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule
